// ==== bmd_ep.f ====
+incdir+src
src/bmd_pkg.sv
src/bmd_ep_ctrl.sv
src/bmd_cq_rx.sv
src/bmd_cc_tx.sv
src/bmd_rq_tx.sv
src/bmd_intr.sv
src/bmd_ep_top.sv
dv/bmd_ep_tb.sv

// ==== dv/bmd_ep_tb.sv ====
// Self-checking testbench for the DMA endpoint, random stimulus from a fixed seed
// Register and TLP model here, DUT outputs sampled on the falling edge
`timescale 1ns/1ps
`default_nettype none
`include "bmd_cfg.svh"

module bmd_ep_tb import bmd_pkg::*; ();

   localparam int SEED    = 43044;
   localparam int TIMEOUT = 1000; // Cycles per wait

   logic          user_clk;
   logic          rst_n_i;
   logic          cq_valid_i;
   bmd_cq_req_t   cq_req_i;
   logic          cq_ready_o;
   logic          cc_valid_o;
   bmd_cpl_t      cc_cpl_o;
   logic          cc_ready_i;
   logic          rq_valid_o;
   bmd_rq_tlp_t   rq_tlp_o;
   logic          rq_ready_i;
   logic          cfg_interrupt_sent_i;
   logic [3:0]    cfg_interrupt_int_o;
   logic          interrupt_done_o;

   logic [31:0]   model_regs [0:15];
   logic          model_done;
   bmd_rq_tlp_t   exp_tlp_q [$];
   bmd_cpl_t      cpl_q [$];
   logic          bp_en;
   logic          int_armed;      // INTA may rise

   bmd_ep_top dut0 (.*);

   initial user_clk = 1'b0;
   always #4 user_clk = ~user_clk;

   // ------------------------------------------------------------------------
   // Checks and model
   // ------------------------------------------------------------------------
   task automatic check_equal(input string name, input logic [127:0] exp,
                              input logic [127:0] act);
      assert (act === exp) else begin
         $display("** Error %s: expected %0h, actual %0h", name, exp, act);
         $display("=== FAIL ===");
         $fatal(1, "check %s failed", name);
      end
   endtask

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("=== FAIL ===");
      $fatal(1, "run aborted");
   endtask

   function automatic logic [31:0] expected_reg(input int off);
      logic [31:0] v;
      if (off == `BMD_REG_DCSR) v = {`BMD_VERSION, 24'h0};
      else if (off >= `BMD_NUM_REGS) v = '0;
      else v = model_regs[off];
      if (off == `BMD_REG_DDMACR) v[`BMD_DDMACR_DONE_BIT] = model_done; // Status bit
      return v;
   endfunction

   // Ready back-pressure and capture of everything that leaves the DUT
   always @(negedge user_clk) begin
      if (rst_n_i) begin
         cc_ready_i = bp_en ? ($urandom % 4) != 0 : 1'b1;
         rq_ready_i = bp_en ? ($urandom % 3) != 0 : 1'b1;
         if (cc_valid_o && cc_ready_i) cpl_q.push_back(cc_cpl_o);
         if (rq_valid_o && rq_ready_i) begin
            if (exp_tlp_q.size() == 0) fail_now("A write TLP was sent with none expected");
            else check_equal("rq_tlp", exp_tlp_q.pop_front(), rq_tlp_o);
         end
         if (cfg_interrupt_int_o[0] && (!int_armed || exp_tlp_q.size() != 0))
            fail_now("INTA was asserted when no interrupt was due");
         check_equal("intb_to_intd", 0, cfg_interrupt_int_o[3:1]);
      end
   end

   // ------------------------------------------------------------------------
   // Request path tasks, called on the falling edge
   // ------------------------------------------------------------------------
   task automatic write_reg(input logic [3:0] off, input logic [31:0] data);
      int wait_cnt;
      wait_cnt = 0;
      cq_req_i   = '{op: REQ_MWR, offset: off, data: data,
                     rid: 16'($urandom), tag: 8'($urandom)};
      cq_valid_i = 1'b1;
      while (!cq_ready_o) begin
         wait_cnt++;
         if (wait_cnt > TIMEOUT) fail_now("Request path never became ready for a write");
         @(negedge user_clk);
      end
      @(negedge user_clk);
      cq_valid_i = 1'b0;
   endtask

   task automatic read_reg(input logic [3:0] off, output bmd_cpl_t cpl);
      logic [15:0]  rid;
      logic [7:0]   tag;
      int           wait_cnt;
      rid        = 16'($urandom);
      tag        = 8'($urandom);
      wait_cnt   = 0;
      cq_req_i   = '{op: REQ_MRD, offset: off, data: 32'($urandom), rid: rid, tag: tag};
      cq_valid_i = 1'b1;
      while (!cq_ready_o) begin
         wait_cnt++;
         if (wait_cnt > TIMEOUT) fail_now("Request path never became ready for a read");
         @(negedge user_clk);
      end
      check_equal("cpl_queue_idle", 0, cpl_q.size());
      @(negedge user_clk);
      cq_valid_i = 1'b0;
      check_equal("cq_stall_after_read", 0, cq_ready_o);
      check_equal("cc_valid_clk1", 0, cc_valid_o);
      @(negedge user_clk);
      check_equal("cc_valid_after_2clk", 1, cc_valid_o); // Seen high on the second edge
      wait_cnt = 0;
      while (cpl_q.size() == 0) begin
         check_equal("cq_stall_pending", 0, cq_ready_o);
         wait_cnt++;
         if (wait_cnt > TIMEOUT) fail_now("Read completion was never accepted");
         @(negedge user_clk);
      end
      cpl = cpl_q.pop_front();
      check_equal("cpl_rid", rid, cpl.rid);
      check_equal("cpl_tag", tag, cpl.tag);
      repeat (2) @(negedge user_clk);
      check_equal("cpl_duplicate", 0, cpl_q.size());
      check_equal("cc_valid_after_take", 0, cc_valid_o);
   endtask

   task automatic read_and_compare(input int off, input string name);
      bmd_cpl_t cpl;
      read_reg(4'(off), cpl);
      check_equal({name, "_status"}, off >= `BMD_NUM_REGS ? CPL_UR : CPL_SC, cpl.status);
      check_equal({name, "_data"}, expected_reg(off), cpl.data);
   endtask

   // Done shows in DDMACR once the last TLP is taken
   task automatic poll_dma_done();
      bmd_cpl_t cpl;
      int       polls;
      polls = 0;
      do begin
         read_reg(4'(`BMD_REG_DDMACR), cpl);
         polls++;
         if (polls > 200) fail_now("DMA done bit never set");
      end while (!cpl.data[`BMD_DDMACR_DONE_BIT]);
      model_done = 1'b1;
      check_equal("tlps_left_at_done", 0, exp_tlp_q.size());
      check_equal("ddmacr_at_done", expected_reg(`BMD_REG_DDMACR), cpl.data);
   endtask

   // Host side of the legacy interrupt, assert then deassert message
   task automatic serve_interrupt();
      int wait_cnt;
      wait_cnt = 0;
      while (!cfg_interrupt_int_o[0]) begin
         wait_cnt++;
         if (wait_cnt > TIMEOUT) fail_now("INTA never rose after the DMA finished");
         @(negedge user_clk);
      end
      repeat ($urandom_range(0, 4)) @(negedge user_clk);
      check_equal("inta_held", 1, cfg_interrupt_int_o[0]);
      cfg_interrupt_sent_i = 1'b1;
      @(negedge user_clk);
      cfg_interrupt_sent_i = 1'b0;
      check_equal("inta_drop", 0, cfg_interrupt_int_o[0]);
      check_equal("int_done_early", 0, interrupt_done_o);
      repeat ($urandom_range(0, 4)) @(negedge user_clk);
      cfg_interrupt_sent_i = 1'b1;
      @(negedge user_clk);
      cfg_interrupt_sent_i = 1'b0;
      check_equal("int_done_pulse", 1, interrupt_done_o);
      @(negedge user_clk);
      check_equal("int_done_one_cycle", 0, interrupt_done_o);
      int_armed = 1'b0;
   endtask

   // ------------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------------
   initial begin
      logic [3:0]   off;
      logic [31:0]  data;
      logic [31:0]  addr;
      logic [31:0]  pat;
      int           len;
      int           count;
      logic         intdis;
      void'($urandom(SEED));
      rst_n_i = 1'b0;
      cq_valid_i = 1'b0;
      cq_req_i = '0;
      cc_ready_i = 1'b1;
      rq_ready_i = 1'b1;
      cfg_interrupt_sent_i = 1'b0;
      model_regs = '{default: '0};
      model_done = 1'b0;
      bp_en = 1'b0;
      int_armed = 1'b0;
      repeat (8) @(negedge user_clk);
      rst_n_i = 1'b1;
      @(negedge user_clk);
      check_equal("reset_cq_ready", 1, cq_ready_o);
      check_equal("reset_cc_valid", 0, cc_valid_o);
      check_equal("reset_rq_valid", 0, rq_valid_o);
      check_equal("reset_int", 0, {cfg_interrupt_int_o, interrupt_done_o});

      // Register readback
      for (int i = 0; i < 16; i++) begin
         off = 4'(2 + $urandom % 4);
         data = $urandom;
         write_reg(off, data);
         model_regs[off] = data;
         read_and_compare($urandom % `BMD_NUM_REGS, "readback");
      end
      for (int r = 0; r < `BMD_NUM_REGS; r++) read_and_compare(r, "readback_all");

      // Unmapped offsets answer UR and hold no state
      bp_en = 1'b1;
      for (int r = `BMD_NUM_REGS; r < 16; r++) begin
         read_and_compare(r, "ur_read");
         write_reg(4'(r), $urandom);
      end
      for (int r = 1; r < `BMD_NUM_REGS; r++) read_and_compare(r, "after_ur_write");

      // Write DMA runs, first one empty
      for (int run = 0; run < 8; run++) begin
         bp_en  = run >= 2;
         intdis = (run == 1 || run == 4) ? 1'b1 : 1'($urandom % 4 == 0);
         count  = run == 0 ? 0 : $urandom % 7;
         len    = $urandom_range(1, 16);
         addr   = $urandom;
         pat    = $urandom;
         write_reg(`BMD_REG_WDMATLPA, addr);
         write_reg(`BMD_REG_WDMATLPS, 32'(len));
         write_reg(`BMD_REG_WDMATLPC, 32'(count));
         write_reg(`BMD_REG_WDMATLPP, pat);
         model_regs[`BMD_REG_WDMATLPA] = addr;
         model_regs[`BMD_REG_WDMATLPS] = 32'(len);
         model_regs[`BMD_REG_WDMATLPC] = 32'(count);
         model_regs[`BMD_REG_WDMATLPP] = pat;
         for (int i = 0; i < count; i++)
            exp_tlp_q.push_back(bmd_rq_tlp_t'{addr: addr + 32'(i * len * 4),
                                              len: 11'(len), tag: 8'(i), pattern: pat});
         int_armed = !intdis;
         data = '0;
         data[`BMD_DDMACR_START_BIT] = 1'b1;
         data[`BMD_DDMACR_INTDIS_BIT] = intdis;
         write_reg(`BMD_REG_DDMACR, data);
         model_regs[`BMD_REG_DDMACR] = data;
         poll_dma_done();
         if (!intdis) serve_interrupt();
         else repeat (12) @(negedge user_clk); // INTA must stay low here
      end

      // Init reset clears the bank
      write_reg(`BMD_REG_DCSR, $urandom | 32'h1);
      model_regs = '{default: '0};
      model_done = 1'b0;
      for (int r = 0; r < `BMD_NUM_REGS; r++) read_and_compare(r, "after_init");

      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src/bmd_cc_tx.sv ====
// Completion builder for register reads
// Holds each completion on the CC path until it is accepted
`timescale 1ns/1ps
`default_nettype none
`include "bmd_cfg.svh"

module bmd_cc_tx import bmd_pkg::*; (
   input  wire                    user_clk,
   input  wire                    rst_n_i,
   input  wire                    cpl_load_i,
   input  wire bmd_cpl_t          cpl_i,
   input  wire [`BMD_RID_W-1:0]   req_rid_i,
   input  wire [`BMD_TAG_W-1:0]   req_tag_i,
   output logic                   cc_valid_o,
   output bmd_cpl_t               cc_cpl_o,
   input  wire                    cc_ready_i,
   output logic                   cpl_done_o
);

   logic      valid_q;
   bmd_cpl_t  cpl_q;

   always_ff @(posedge user_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
      end else if (cpl_load_i) begin
         valid_q <= 1'b1;
      end else if (cc_ready_i) begin
         valid_q <= 1'b0;
      end
   end

   // Status and data from the register bank, ID and tag from the request
   always_ff @(posedge user_clk) begin
      if (cpl_load_i) begin
         cpl_q <= '{status: cpl_i.status,
                    rid:    req_rid_i,
                    tag:    req_tag_i,
                    data:   cpl_i.data};
      end
   end

   assign cc_valid_o = valid_q;
   assign cc_cpl_o   = cpl_q;
   assign cpl_done_o = valid_q && cc_ready_i;

   a_cc_hold: assert property (@(posedge user_clk) disable iff (!rst_n_i)
      (cc_valid_o && !cc_ready_i) |=> cc_valid_o && $stable(cc_cpl_o));

endmodule

`default_nettype wire

// ==== src/bmd_cfg.svh ====
// Widths, register map and control bits of the bus-master DMA endpoint
// Pulled in with `include by the package and the RTL modules
`ifndef BMD_CFG_SVH
`define BMD_CFG_SVH

`define BMD_ADDR_W   4     // Register dword offset
`define BMD_DATA_W   32
`define BMD_LEN_W    11    // TLP length in dwords
`define BMD_CNT_W    16    // TLPs per DMA run
`define BMD_TAG_W    8
`define BMD_RID_W    16
`define BMD_VERSION  8'h12 // Shows in DCSR[31:24]

// Register map, in dwords
`define BMD_REG_DCSR      0
`define BMD_REG_DDMACR    1
`define BMD_REG_WDMATLPA  2
`define BMD_REG_WDMATLPS  3
`define BMD_REG_WDMATLPC  4
`define BMD_REG_WDMATLPP  5
`define BMD_NUM_REGS      6

`define BMD_DCSR_INIT_BIT      0
`define BMD_DDMACR_START_BIT   0
`define BMD_DDMACR_INTDIS_BIT  7
`define BMD_DDMACR_DONE_BIT    8

`endif

// ==== src/bmd_cq_rx.sv ====
// Completer request capture for single-dword register accesses
// Stalls the request path while a read completion is outstanding
`timescale 1ns/1ps
`default_nettype none
`include "bmd_cfg.svh"

module bmd_cq_rx import bmd_pkg::*; (
   input  wire                      user_clk,
   input  wire                      rst_n_i,
   input  wire                      cq_valid_i,
   input  wire bmd_cq_req_t         cq_req_i,
   output logic                     cq_ready_o,
   input  wire                      cpl_done_i,
   output bmd_reg_acc_t             reg_acc_o,
   output logic [`BMD_RID_W-1:0]    req_rid_o,
   output logic [`BMD_TAG_W-1:0]    req_tag_o
);

   logic                    xfer;
   logic                    rd_pend_q;
   logic                    acc_rd_q;
   logic                    acc_wr_q;
   logic [`BMD_ADDR_W-1:0]  acc_off_q;
   logic [`BMD_DATA_W-1:0]  acc_data_q;

   assign cq_ready_o = !rd_pend_q;
   assign xfer       = cq_valid_i && cq_ready_o;

   always_ff @(posedge user_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         acc_rd_q  <= 1'b0;
         acc_wr_q  <= 1'b0;
         rd_pend_q <= 1'b0;
      end else begin
         acc_rd_q <= xfer && cq_req_i.op == REQ_MRD; // One-cycle strobes
         acc_wr_q <= xfer && cq_req_i.op == REQ_MWR;
         if (cpl_done_i) begin
            rd_pend_q <= 1'b0;
         end else if (xfer && cq_req_i.op == REQ_MRD) begin
            rd_pend_q <= 1'b1;
         end
      end
   end

   // Request fields, kept for the completion
   always_ff @(posedge user_clk) begin
      if (xfer) begin
         acc_off_q  <= cq_req_i.offset;
         acc_data_q <= cq_req_i.data;
         req_rid_o  <= cq_req_i.rid;
         req_tag_o  <= cq_req_i.tag;
      end
   end

   assign reg_acc_o = '{rd: acc_rd_q, wr: acc_wr_q, offset: acc_off_q, data: acc_data_q};

   // A read blocks the path until its completion has left the endpoint
   a_no_xfer_while_rd: assert property (@(posedge user_clk) disable iff (!rst_n_i)
      (xfer && cq_req_i.op == REQ_MRD) |=> !xfer until_with cpl_done_i);

endmodule

`default_nettype wire

// ==== src/bmd_ep_ctrl.sv ====
// Control register bank and write-DMA sequencing
// Answers decoded register accesses and kicks off the TLP generator
`timescale 1ns/1ps
`default_nettype none
`include "bmd_cfg.svh"

module bmd_ep_ctrl import bmd_pkg::*; (
   input  wire                 user_clk,
   input  wire                 rst_n_i,
   input  wire bmd_reg_acc_t   reg_acc_i,
   output logic                cpl_load_o,
   output bmd_cpl_t            cpl_o,
   output logic                dma_start_o,
   output bmd_dma_desc_t       dma_desc_o,
   input  wire                 dma_done_i,
   output logic                intr_req_o
);

   logic [`BMD_DATA_W-1:0]  regs_q [1:`BMD_NUM_REGS-1]; // DCSR holds no state
   logic [`BMD_DATA_W-1:0]  rd_data;
   logic                    unmapped;
   logic                    init_wr;
   logic                    start_ok;
   logic                    start_q;
   logic                    done_q;
   bmd_dma_state_e          dma_state_q;

   assign unmapped = reg_acc_i.offset >= `BMD_NUM_REGS;
   assign init_wr  = reg_acc_i.wr && reg_acc_i.offset == `BMD_REG_DCSR &&
                     reg_acc_i.data[`BMD_DCSR_INIT_BIT];
   // Start only from idle, and only once per pulse
   assign start_ok = reg_acc_i.wr && reg_acc_i.offset == `BMD_REG_DDMACR &&
                     reg_acc_i.data[`BMD_DDMACR_START_BIT] &&
                     dma_state_q == DMA_IDLE && !start_q;

   // ------------------------------------------------------------------------
   // Register bank
   // ------------------------------------------------------------------------
   always_ff @(posedge user_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         regs_q <= '{default: '0};
      end else if (init_wr) begin
         regs_q <= '{default: '0};
      end else if (reg_acc_i.wr && !unmapped && reg_acc_i.offset != `BMD_REG_DCSR) begin
         regs_q[reg_acc_i.offset] <= reg_acc_i.data;
      end
   end

   always_comb begin
      rd_data = '0;
      if (reg_acc_i.offset == `BMD_REG_DCSR) begin
         rd_data[31:24] = `BMD_VERSION;
      end else if (!unmapped) begin
         rd_data = regs_q[reg_acc_i.offset];
      end
      if (reg_acc_i.offset == `BMD_REG_DDMACR) begin
         rd_data[`BMD_DDMACR_DONE_BIT] = done_q; // Status from the engine
      end
   end

   assign cpl_load_o = reg_acc_i.rd;
   assign cpl_o      = '{status: unmapped ? CPL_UR : CPL_SC,
                         rid:    '0,              // Filled in by the completion path
                         tag:    '0,
                         data:   rd_data};        // Zero for unmapped offsets

   assign dma_desc_o = '{addr:    regs_q[`BMD_REG_WDMATLPA],
                         len:     regs_q[`BMD_REG_WDMATLPS][`BMD_LEN_W-1:0],
                         count:   regs_q[`BMD_REG_WDMATLPC][`BMD_CNT_W-1:0],
                         pattern: regs_q[`BMD_REG_WDMATLPP]};

   // ------------------------------------------------------------------------
   // Write-DMA FSM
   // ------------------------------------------------------------------------
   always_ff @(posedge user_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         dma_state_q <= DMA_IDLE;
         start_q     <= 1'b0;
         done_q      <= 1'b0;
      end else if (init_wr) begin
         dma_state_q <= DMA_IDLE;
         start_q     <= 1'b0;
         done_q      <= 1'b0;
      end else begin
         start_q <= start_ok;
         if (start_ok) begin
            done_q <= 1'b0;
         end
         case (dma_state_q)
            DMA_IDLE: begin
               if (start_q) begin
                  dma_state_q <= DMA_RUN;
               end
            end
            DMA_RUN: begin
               if (dma_done_i) begin
                  done_q      <= 1'b1;
                  dma_state_q <= regs_q[`BMD_REG_DDMACR][`BMD_DDMACR_INTDIS_BIT] ?
                                 DMA_IDLE : DMA_INTR;
               end
            end
            default: dma_state_q <= DMA_IDLE; // One cycle in DMA_INTR
         endcase
      end
   end

   assign dma_start_o = start_q;
   assign intr_req_o  = dma_state_q == DMA_INTR;

   // The start pulse lands while the FSM still sits in idle
   a_start_in_idle: assert property (@(posedge user_clk) disable iff (!rst_n_i)
      dma_start_o |-> dma_state_q == DMA_IDLE);

endmodule

`default_nettype wire

// ==== src/bmd_ep_top.sv ====
// Top of the DMA endpoint application behind the PCIe block
// Connects the register bank to the request, completion and interrupt paths
`timescale 1ns/1ps
`default_nettype none
`include "bmd_cfg.svh"

module bmd_ep_top import bmd_pkg::*; (
   input  wire               user_clk,
   input  wire               rst_n_i,
   // Completer request
   input  wire               cq_valid_i,
   input  wire bmd_cq_req_t  cq_req_i,
   output logic              cq_ready_o,
   // Completer completion
   output logic              cc_valid_o,
   output bmd_cpl_t          cc_cpl_o,
   input  wire               cc_ready_i,
   // Requester request
   output logic              rq_valid_o,
   output bmd_rq_tlp_t       rq_tlp_o,
   input  wire               rq_ready_i,
   // Legacy interrupt
   input  wire               cfg_interrupt_sent_i,
   output logic [3:0]        cfg_interrupt_int_o,
   output logic              interrupt_done_o
);

   bmd_reg_acc_t             reg_acc;
   logic                     cpl_load;
   bmd_cpl_t                 cpl;
   logic                     cpl_done;
   logic [`BMD_RID_W-1:0]    req_rid;
   logic [`BMD_TAG_W-1:0]    req_tag;
   logic                     dma_start;
   bmd_dma_desc_t            dma_desc;
   logic                     dma_done;
   logic                     intr_req;

   bmd_ep_ctrl ctrl0 (
      .user_clk    ( user_clk ),
      .rst_n_i     ( rst_n_i ),
      .reg_acc_i   ( reg_acc ),
      .cpl_load_o  ( cpl_load ),
      .cpl_o       ( cpl ),
      .dma_start_o ( dma_start ),
      .dma_desc_o  ( dma_desc ),
      .dma_done_i  ( dma_done ),
      .intr_req_o  ( intr_req )
   );

   bmd_cq_rx cq0 (
      .user_clk    ( user_clk ),
      .rst_n_i     ( rst_n_i ),
      .cq_valid_i  ( cq_valid_i ),
      .cq_req_i    ( cq_req_i ),
      .cq_ready_o  ( cq_ready_o ),
      .cpl_done_i  ( cpl_done ),
      .reg_acc_o   ( reg_acc ),
      .req_rid_o   ( req_rid ),
      .req_tag_o   ( req_tag )
   );

   bmd_cc_tx cc0 (
      .user_clk    ( user_clk ),
      .rst_n_i     ( rst_n_i ),
      .cpl_load_i  ( cpl_load ),
      .cpl_i       ( cpl ),
      .req_rid_i   ( req_rid ),
      .req_tag_i   ( req_tag ),
      .cc_valid_o  ( cc_valid_o ),
      .cc_cpl_o    ( cc_cpl_o ),
      .cc_ready_i  ( cc_ready_i ),
      .cpl_done_o  ( cpl_done )
   );

   bmd_rq_tx rq0 (
      .user_clk    ( user_clk ),
      .rst_n_i     ( rst_n_i ),
      .dma_start_i ( dma_start ),
      .dma_desc_i  ( dma_desc ),
      .rq_valid_o  ( rq_valid_o ),
      .rq_tlp_o    ( rq_tlp_o ),
      .rq_ready_i  ( rq_ready_i ),
      .dma_done_o  ( dma_done )
   );

   bmd_intr intr0 (
      .user_clk             ( user_clk ),
      .rst_n_i              ( rst_n_i ),
      .intr_req_i           ( intr_req ),
      .cfg_interrupt_sent_i ( cfg_interrupt_sent_i ),
      .cfg_interrupt_int_o  ( cfg_interrupt_int_o ),
      .interrupt_done_o     ( interrupt_done_o )
   );

endmodule

`default_nettype wire

// ==== src/bmd_intr.sv ====
// Legacy INTA sequencer, assert then deassert through the PCIe core
// Pulses interrupt_done_o once the deassert message has gone out
`timescale 1ns/1ps
`default_nettype none

module bmd_intr (
   input  wire          user_clk,
   input  wire          rst_n_i,
   input  wire          intr_req_i,
   input  wire          cfg_interrupt_sent_i,
   output logic [3:0]   cfg_interrupt_int_o,
   output logic         interrupt_done_o
);

   typedef enum logic [1:0] {
      INT_IDLE,
      INT_ASSERT,    // INTA high, wait for the assert message
      INT_DEASSERT   // INTA low, wait for the deassert message
   } int_state_e;

   int_state_e  state_q;
   logic        done_q;

   always_ff @(posedge user_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= INT_IDLE;
         done_q  <= 1'b0;
      end else begin
         done_q <= 1'b0;
         case (state_q)
            INT_IDLE: begin
               if (intr_req_i) begin
                  state_q <= INT_ASSERT;
               end
            end
            INT_ASSERT: begin
               if (cfg_interrupt_sent_i) begin
                  state_q <= INT_DEASSERT;
               end
            end
            default: begin
               if (cfg_interrupt_sent_i) begin
                  state_q <= INT_IDLE;
                  done_q  <= 1'b1;
               end
            end
         endcase
      end
   end

   assign cfg_interrupt_int_o = {3'b000, state_q == INT_ASSERT}; // INTB..INTD unused
   assign interrupt_done_o    = done_q;

endmodule

`default_nettype wire

// ==== src/bmd_pkg.sv ====
// Enums and packed structs passed between the endpoint blocks
// Modules pick these up with a wildcard import in their header
`default_nettype none
`include "bmd_cfg.svh"

package bmd_pkg;

   typedef enum logic {
      REQ_MRD,
      REQ_MWR
   } bmd_req_op_e;

   typedef enum logic {
      CPL_SC,
      CPL_UR
   } bmd_cpl_status_e;

   typedef enum logic [1:0] {
      DMA_IDLE,
      DMA_RUN,
      DMA_INTR
   } bmd_dma_state_e;

   // ------------------------------------------------------------------------
   // Stream beats, one struct per TLP
   // ------------------------------------------------------------------------
   typedef struct packed {
      bmd_req_op_e             op;
      logic [`BMD_ADDR_W-1:0]  offset;
      logic [`BMD_DATA_W-1:0]  data;    // Write data, MWR only
      logic [`BMD_RID_W-1:0]   rid;
      logic [`BMD_TAG_W-1:0]   tag;
   } bmd_cq_req_t;

   typedef struct packed {
      logic                    rd;
      logic                    wr;
      logic [`BMD_ADDR_W-1:0]  offset;
      logic [`BMD_DATA_W-1:0]  data;
   } bmd_reg_acc_t;

   typedef struct packed {
      bmd_cpl_status_e         status;
      logic [`BMD_RID_W-1:0]   rid;
      logic [`BMD_TAG_W-1:0]   tag;
      logic [`BMD_DATA_W-1:0]  data;
   } bmd_cpl_t;

   typedef struct packed {
      logic [`BMD_DATA_W-1:0]  addr;
      logic [`BMD_LEN_W-1:0]   len;
      logic [`BMD_TAG_W-1:0]   tag;
      logic [`BMD_DATA_W-1:0]  pattern; // Every payload dword
   } bmd_rq_tlp_t;

   typedef struct packed {
      logic [`BMD_DATA_W-1:0]  addr;
      logic [`BMD_LEN_W-1:0]   len;
      logic [`BMD_CNT_W-1:0]   count;
      logic [`BMD_DATA_W-1:0]  pattern;
   } bmd_dma_desc_t;

endpackage

`default_nettype wire

// ==== src/bmd_rq_tx.sv ====
// Memory-write TLP generator for the write DMA
// Sends count TLPs, stepping the address by the TLP size and the tag by one
`timescale 1ns/1ps
`default_nettype none
`include "bmd_cfg.svh"

module bmd_rq_tx import bmd_pkg::*; (
   input  wire                   user_clk,
   input  wire                   rst_n_i,
   input  wire                   dma_start_i,
   input  wire bmd_dma_desc_t    dma_desc_i,
   output logic                  rq_valid_o,
   output bmd_rq_tlp_t           rq_tlp_o,
   input  wire                   rq_ready_i,
   output logic                  dma_done_o
);

   localparam int ADDR_W = `BMD_DATA_W;

   logic                    valid_q;
   logic                    done_q;
   logic                    accept;
   logic [`BMD_CNT_W-1:0]   left_q;  // TLPs still to send, this one included
   logic [ADDR_W-1:0]       addr_q;
   logic [`BMD_LEN_W-1:0]   len_q;
   logic [`BMD_TAG_W-1:0]   tag_q;
   logic [`BMD_DATA_W-1:0]  pat_q;

   assign accept = valid_q && rq_ready_i;

   // ------------------------------------------------------------------------
   // Control, a new run is ignored while a train is going
   // ------------------------------------------------------------------------
   always_ff @(posedge user_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
         done_q  <= 1'b0;
      end else begin
         done_q <= 1'b0;
         if (dma_start_i && !valid_q) begin
            valid_q <= dma_desc_i.count != '0;
            done_q  <= dma_desc_i.count == '0; // Empty run ends at once
         end else if (accept && left_q == 1) begin
            valid_q <= 1'b0;
            done_q  <= 1'b1;
         end
      end
   end

   // TLP fields
   always_ff @(posedge user_clk) begin
      if (dma_start_i && !valid_q) begin
         addr_q <= dma_desc_i.addr;
         len_q  <= dma_desc_i.len;
         pat_q  <= dma_desc_i.pattern;
         left_q <= dma_desc_i.count;
         tag_q  <= '0;
      end else if (accept) begin
         addr_q <= addr_q + ADDR_W'({len_q, 2'b00}); // Length in bytes
         tag_q  <= tag_q + 1'b1;
         left_q <= left_q - 1'b1;
      end
   end

   assign rq_valid_o = valid_q;
   assign rq_tlp_o   = '{addr: addr_q, len: len_q, tag: tag_q, pattern: pat_q};
   assign dma_done_o = done_q;

   a_rq_hold: assert property (@(posedge user_clk) disable iff (!rst_n_i)
      (rq_valid_o && !rq_ready_i) |=> rq_valid_o && $stable(rq_tlp_o));

endmodule

`default_nettype wire
